/* design/bus_decode.sv */
`timescale 1ns/1ps
`include "msx_bus_macros.svh"

module bus_decode (
	// CPU bus
	input	msx_bus_pkg::bus_addr_t		a,
	input	logic						mreq_n,
	input	logic						iorq_n,
	input	logic						rd_n,
	input	logic						wr_n,
	input	msx_bus_pkg::bus_data_t		d,
	// Slot selects from the PPI and the expanded slots
	input	msx_bus_pkg::slot_sel_t		pri_slot,
	input	msx_bus_pkg::slot_sel_t		sub_slot0,
	input	msx_bus_pkg::slot_sel_t		sub_slot3,
	// SPI loader
	input	logic						cpu_freeze,
	input	msx_bus_pkg::sdram_addr_t	spi_address,
	input	logic						spi_mreq_n,
	input	msx_bus_pkg::bus_data_t		spi_d,
	// Peripheral selects
	output	logic						ppi_cs_n,
	output	logic						psg_cs_n,
	output	logic						vdp_cs_n,
	// SDRAM port
	output	msx_bus_pkg::sdram_addr_t	sdram_address,
	output	logic						sdram_mreq_n,
	output	logic						sdram_rd_n,
	output	logic						sdram_wr_n,
	output	msx_bus_pkg::bus_data_t		sdram_d
);
	import msx_bus_pkg::*;

	logic			w_ppi_hit;		// Port matches A8h-ABh
	logic			w_psg_hit;		// Port matches A0h-A3h
	logic			w_vdp_hit;		// Port matches 98h-99h

	logic			w_page1;		// 4000h-7FFFh
	logic			w_page12;		// 4000h-BFFFh
	logic			w_lower32k;		// 0000h-7FFFh

	logic			w_mapper;		// Slot 3-0 selected
	sdram_page_t	w_cpu_page;		// Page from the area priority
	logic			w_window;		// Address inside that area's ROM window
	logic			w_cpu_rd_n;		// Read strobe after masking
	logic			w_cpu_wr_n;		// Write strobe, Mapper RAM only

	// ----------------------------------------
	// I/O port decode
	// ----------------------------------------
	// Only the low address byte carries the port number
	assign w_ppi_hit	= ( { a[7:2], 2'b00 } == `MSX_PPI_PORT );	// Four ports
	assign w_psg_hit	= ( { a[7:2], 2'b00 } == `MSX_PSG_PORT );	// Four ports
	assign w_vdp_hit	= ( { a[7:1], 1'b0 } == `MSX_VDP_PORT );		// Two ports

	// Select follows iorq_n on a hit, idle high otherwise
	assign ppi_cs_n		= w_ppi_hit ? iorq_n : 1'b1;
	assign psg_cs_n		= w_psg_hit ? iorq_n : 1'b1;
	assign vdp_cs_n		= w_vdp_hit ? iorq_n : 1'b1;

	// ----------------------------------------
	// CPU page windows
	// ----------------------------------------
	assign w_page1		= ( a[15:14] == 2'b01 );
	assign w_page12		= ( a[15:14] == 2'b01 ) || ( a[15:14] == 2'b10 );
	assign w_lower32k	= ~a[15];

	assign w_mapper		= sub_slot3[0];

	// ----------------------------------------
	// Slot memory map
	// ----------------------------------------
	// First hit wins, top of the chain is highest priority
	always_comb begin
		w_cpu_page	= '0;			// No area, page zero
		w_window	= 1'b0;			// And no read
		if( sub_slot3[0] ) begin
			// Mapper RAM, 64 KB visible through all four pages
			w_cpu_page	= `MSX_PAGE_MAPPER | sdram_page_t'( a[15:13] );
			w_window	= 1'b1;
		end
		else if( pri_slot[1] ) begin
			// 1 MB MegaROM in slot 1
			w_cpu_page	= `MSX_PAGE_MEGA1M | sdram_page_t'( { ~a[14], a[13] } );
			w_window	= w_page12;
		end
		else if( pri_slot[2] ) begin
			w_cpu_page	= `MSX_PAGE_MEGA512K;		// Slot 2, one fixed page
			w_window	= w_page12;
		end
		else if( sub_slot0[3] ) begin
			// Logo and extended BASIC in slot 0-3
			w_cpu_page	= `MSX_PAGE_LOGO | sdram_page_t'( a[14:13] );
			w_window	= w_page12;
		end
		else if( sub_slot0[2] ) begin
			w_cpu_page	= `MSX_PAGE_MUSIC | sdram_page_t'( a[13] );	// 16 KB ROM
			w_window	= w_page1;
		end
		else if( sub_slot0[1] ) begin
			w_cpu_page	= `MSX_PAGE_IOT | sdram_page_t'( a[13] );	// 16 KB ROM
			w_window	= w_page1;
		end
		else if( sub_slot3[1] ) begin
			// Sub ROM and Kanji BASIC in slot 3-1
			w_cpu_page	= `MSX_PAGE_SUB | sdram_page_t'( a[14:13] );
			w_window	= w_lower32k;
		end
		else if( sub_slot0[0] ) begin
			w_cpu_page	= `MSX_PAGE_MAIN | sdram_page_t'( a[14:13] );	// 32 KB main ROM
			w_window	= w_lower32k;
		end
		else if( sub_slot3[2] ) begin
			// Nextor in slot 3-2
			w_cpu_page	= `MSX_PAGE_NEXTOR | sdram_page_t'( a[15:13] );
			w_window	= w_page12;
		end
	end

	// I/O cycles never reach SDRAM
	assign w_cpu_rd_n	= ( !iorq_n ) ? 1'b1 :
						  ( w_window ) ? rd_n : 1'b1;

	// Everything but Mapper RAM is ROM
	assign w_cpu_wr_n	= w_mapper ? wr_n : 1'b1;

	// ----------------------------------------
	// SDRAM port and loader handover
	// ----------------------------------------
	// Loader owns address, data and request while the CPU is frozen
	assign sdram_address	= cpu_freeze ? spi_address : { w_cpu_page, a[12:0] };
	assign sdram_d			= cpu_freeze ? spi_d : d;
	assign sdram_mreq_n		= cpu_freeze ? spi_mreq_n : mreq_n;
	assign sdram_wr_n		= cpu_freeze ? spi_mreq_n : w_cpu_wr_n;	// Loader only writes
	assign sdram_rd_n		= w_cpu_rd_n;

endmodule

/* design/clock_enable_gen.sv */
`timescale 1ns/1ps
`include "msx_bus_macros.svh"

module clock_enable_gen (
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	sdram_busy,		// SDRAM controller back-pressure
	input	logic	cpu_freeze,		// Loader holds the CPU
	output	logic	half_enable,	// UART pace, every second cycle
	output	logic	cpu_enable,		// One in six cycles
	output	logic	psg_enable		// One in twelve cycles
);
	logic			ff_half_div;
	logic	[2:0]	ff_cpu_div;
	logic	[3:0]	ff_psg_div;
	logic			w_run;			// Neither busy nor frozen

	// ----------------------------------------
	// Half rate toggle
	// ----------------------------------------
	always_ff @( posedge clk42m ) begin
		if( !ff_reset_n ) begin
			ff_half_div <= 1'b0;
		end
		else begin
			ff_half_div <= ~ff_half_div;
		end
	end

	assign half_enable	= ff_half_div;		// Ignores busy and freeze

	// ----------------------------------------
	// CPU and PSG dividers
	// ----------------------------------------
	// Freeze restarts both counts from zero
	always_ff @( posedge clk42m ) begin
		if( !ff_reset_n ) begin
			ff_cpu_div <= 3'd0;
		end
		else if( cpu_freeze ) begin
			ff_cpu_div <= 3'd0;
		end
		else if( ff_cpu_div == `MSX_CPU_DIV_LAST ) begin
			ff_cpu_div <= 3'd0;				// Wrap
		end
		else begin
			ff_cpu_div <= ff_cpu_div + 3'd1;
		end
	end

	always_ff @( posedge clk42m ) begin
		if( !ff_reset_n ) begin
			ff_psg_div <= 4'd0;
		end
		else if( cpu_freeze ) begin
			ff_psg_div <= 4'd0;
		end
		else if( ff_psg_div == `MSX_PSG_DIV_LAST ) begin
			ff_psg_div <= 4'd0;
		end
		else begin
			ff_psg_div <= ff_psg_div + 4'd1;
		end
	end

	// Busy masks the pulse but the count keeps going
	assign w_run		= !sdram_busy && !cpu_freeze;
	assign cpu_enable	= ( ff_cpu_div == `MSX_CPU_DIV_LAST ) && w_run;
	assign psg_enable	= ( ff_psg_div == `MSX_PSG_DIV_LAST ) && w_run;

endmodule

/* design/msx_bus_glue.sv */
`timescale 1ns/1ps

module msx_bus_glue (
	input	logic						clk42m,
	input	logic						ff_reset_n,
	// CPU bus
	input	msx_bus_pkg::bus_addr_t		a,
	input	logic						mreq_n,
	input	logic						iorq_n,
	input	logic						rd_n,
	input	logic						wr_n,
	input	msx_bus_pkg::bus_data_t		d,
	// Slots
	input	msx_bus_pkg::slot_sel_t		pri_slot,
	input	msx_bus_pkg::slot_sel_t		sub_slot0,
	input	msx_bus_pkg::slot_sel_t		sub_slot3,
	// SPI loader
	input	logic						cpu_freeze,
	input	msx_bus_pkg::sdram_addr_t	spi_address,
	input	logic						spi_mreq_n,
	input	msx_bus_pkg::bus_data_t		spi_d,
	input	logic						sdram_busy,
	// Responders
	input	msx_bus_pkg::bus_data_t		sdram_q,
	input	msx_bus_pkg::bus_data_t		uart_q,
	input	msx_bus_pkg::bus_data_t		expslt0_q,
	input	msx_bus_pkg::bus_data_t		expslt3_q,
	input	msx_bus_pkg::bus_data_t		ppi_q,
	input	logic						sdram_q_en,
	input	logic						uart_q_en,
	input	logic						expslt0_q_en,
	input	logic						expslt3_q_en,
	input	logic						ppi_q_en,
	// Selects
	output	logic						ppi_cs_n,
	output	logic						psg_cs_n,
	output	logic						vdp_cs_n,
	// SDRAM port
	output	msx_bus_pkg::sdram_addr_t	sdram_address,
	output	logic						sdram_mreq_n,
	output	logic						sdram_rd_n,
	output	logic						sdram_wr_n,
	output	msx_bus_pkg::bus_data_t		sdram_d,
	// Clock enables
	output	logic						half_enable,
	output	logic						cpu_enable,
	output	logic						psg_enable,
	output	msx_bus_pkg::bus_data_t		cpu_rdata	// Byte the CPU reads
);

	// ----------------------------------------
	// Decode
	// ----------------------------------------
	bus_decode u_bus_decode (
		.a				( a				),
		.mreq_n			( mreq_n		),
		.iorq_n			( iorq_n		),
		.rd_n			( rd_n			),
		.wr_n			( wr_n			),
		.d				( d				),
		.pri_slot		( pri_slot		),
		.sub_slot0		( sub_slot0		),
		.sub_slot3		( sub_slot3		),
		.cpu_freeze		( cpu_freeze	),
		.spi_address	( spi_address	),
		.spi_mreq_n		( spi_mreq_n	),
		.spi_d			( spi_d			),
		.ppi_cs_n		( ppi_cs_n		),
		.psg_cs_n		( psg_cs_n		),
		.vdp_cs_n		( vdp_cs_n		),
		.sdram_address	( sdram_address	),
		.sdram_mreq_n	( sdram_mreq_n	),
		.sdram_rd_n		( sdram_rd_n	),
		.sdram_wr_n		( sdram_wr_n	),
		.sdram_d		( sdram_d		)
	);

	// ----------------------------------------
	// Clock enables
	// ----------------------------------------
	clock_enable_gen u_clock_enable_gen (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.sdram_busy		( sdram_busy	),
		.cpu_freeze		( cpu_freeze	),
		.half_enable	( half_enable	),
		.cpu_enable		( cpu_enable	),
		.psg_enable		( psg_enable	)
	);

	// ----------------------------------------
	// Read data
	// ----------------------------------------
	read_data_latch u_read_data_latch (
		.clk42m			( clk42m		),
		.ff_reset_n		( ff_reset_n	),
		.rd_n			( rd_n			),
		.sdram_q		( sdram_q		),
		.uart_q			( uart_q		),
		.expslt0_q		( expslt0_q		),
		.expslt3_q		( expslt3_q		),
		.ppi_q			( ppi_q			),
		.sdram_q_en		( sdram_q_en	),
		.uart_q_en		( uart_q_en		),
		.expslt0_q_en	( expslt0_q_en	),
		.expslt3_q_en	( expslt3_q_en	),
		.ppi_q_en		( ppi_q_en		),
		.cpu_rdata		( cpu_rdata		)
	);

endmodule

/* design/msx_bus_macros.svh */
`ifndef MSX_BUS_MACROS_SVH
`define MSX_BUS_MACROS_SVH

// ----------------------------------------
// I/O port bases
// ----------------------------------------
`define MSX_PPI_PORT		8'hA8		// PPI at A8h-ABh
`define MSX_PSG_PORT		8'hA0		// PSG at A0h-A3h
`define MSX_VDP_PORT		8'h98		// VDP at 98h-99h

// ----------------------------------------
// Divider end counts
// ----------------------------------------
// Counts run from zero up to these values and wrap
`define MSX_CPU_DIV_LAST	3'd5		// Six clk42m cycles per CPU step
`define MSX_PSG_DIV_LAST	4'd11		// Twelve cycles per PSG step

// ----------------------------------------
// SDRAM page codes
// ----------------------------------------
// Upper ten address bits, one page is 8 KB
// Low bits left zero get address bits ORed in by the decoder
`define MSX_PAGE_MAPPER		10'b1000000000	// Mapper RAM, plus a[15:13]
`define MSX_PAGE_MEGA1M		10'b0100000000	// 1 MB MegaROM, plus ~a[14], a[13]
`define MSX_PAGE_MEGA512K	10'b0000100000	// 512 KB MegaROM, fixed page
`define MSX_PAGE_LOGO		10'b0000011100	// Logo and extended BASIC, plus a[14:13]
`define MSX_PAGE_MUSIC		10'b0000011010	// Music ROM, plus a[13]
`define MSX_PAGE_IOT		10'b0000011000	// IoT BASIC, plus a[13]
`define MSX_PAGE_SUB		10'b0000010100	// Sub ROM and Kanji BASIC, plus a[14:13]
`define MSX_PAGE_MAIN		10'b0000010000	// Main ROM, plus a[14:13]
`define MSX_PAGE_NEXTOR		10'b0000000000	// Nextor, plus a[15:13]

`endif

/* design/msx_bus_pkg.sv */
package msx_bus_pkg;

	// ----------------------------------------
	// CPU side
	// ----------------------------------------

	// Z80 address bus
	typedef logic [15:0]	bus_addr_t;

	// One byte on the data bus
	typedef logic [7:0]		bus_data_t;

	// ----------------------------------------
	// SDRAM side
	// ----------------------------------------

	// Byte address into the 8 MB SDRAM
	typedef logic [22:0]	sdram_addr_t;

	// Upper address bits above the 8 KB page offset
	// 10 page bits plus 13 offset bits make up sdram_addr_t
	typedef logic [9:0]		sdram_page_t;

	// ----------------------------------------
	// Slot selects
	// ----------------------------------------

	// One-hot, bit n selects slot n
	// Same shape for primary slots 0-3
	// and for the secondary slots of expanded slots 0 and 3
	typedef logic [3:0]		slot_sel_t;

endpackage

/* design/read_data_latch.sv */
`timescale 1ns/1ps

module read_data_latch (
	input	logic						clk42m,
	input	logic						ff_reset_n,
	input	logic						rd_n,
	// Read data from each responder
	input	msx_bus_pkg::bus_data_t		sdram_q,
	input	msx_bus_pkg::bus_data_t		uart_q,
	input	msx_bus_pkg::bus_data_t		expslt0_q,
	input	msx_bus_pkg::bus_data_t		expslt3_q,
	input	msx_bus_pkg::bus_data_t		ppi_q,
	// Valid strobes, one cycle wide
	input	logic						sdram_q_en,
	input	logic						uart_q_en,
	input	logic						expslt0_q_en,
	input	logic						expslt3_q_en,
	input	logic						ppi_q_en,
	output	msx_bus_pkg::bus_data_t		cpu_rdata
);
	import msx_bus_pkg::*;

	bus_data_t	w_next_rdata;	// Value for the next edge
	logic		w_load;			// Update this cycle

	// ----------------------------------------
	// Source select
	// ----------------------------------------
	// SDRAM first, PPI last
	always_comb begin
		w_load			= 1'b1;
		w_next_rdata	= 8'hFF;			// Idle bus floats high
		if( sdram_q_en ) begin
			w_next_rdata	= sdram_q;
		end
		else if( uart_q_en ) begin
			w_next_rdata	= uart_q;
		end
		else if( expslt0_q_en ) begin
			w_next_rdata	= expslt0_q;	// Slot 0 expansion register
		end
		else if( expslt3_q_en ) begin
			w_next_rdata	= expslt3_q;	// Slot 3 expansion register
		end
		else if( ppi_q_en ) begin
			w_next_rdata	= ppi_q;
		end
		else if( !rd_n ) begin
			w_load			= 1'b0;			// Read in progress, keep last byte
		end
	end

	// ----------------------------------------
	// Latch
	// ----------------------------------------
	always_ff @( posedge clk42m ) begin
		if( !ff_reset_n ) begin
			cpu_rdata <= 8'hFF;
		end
		else if( w_load ) begin
			cpu_rdata <= w_next_rdata;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bus glue testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_msx_bus_glue -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output	logic	clk42m,
	output	logic	ff_reset_n
);
	// 10 ns period, first rising edge at 5 ns
	initial begin
		clk42m = 1'b0;
		forever #5 clk42m = ~clk42m;
	end

	// Low through the first four rising edges
	initial begin
		ff_reset_n = 1'b0;
		repeat (4) @(posedge clk42m);
		ff_reset_n <= 1'b1;
	end

endmodule

/* verification/tb_msx_bus_glue.sv */
`timescale 1ns/1ps
`include "msx_bus_macros.svh"

module tb_msx_bus_glue;
	import msx_bus_pkg::*;

	localparam int MODE_IDLE	= 0;
	localparam int MODE_IO		= 1;
	localparam int MODE_MAP		= 2;
	localparam int MODE_LOADER	= 3;
	localparam int MODE_LATCH	= 4;

	logic			clk42m;
	logic			ff_reset_n;
	bus_addr_t		a;
	bus_data_t		d;
	logic			mreq_n, iorq_n, rd_n, wr_n;				// CPU strobes
	slot_sel_t		pri_slot, sub_slot0, sub_slot3;
	logic			cpu_freeze, spi_mreq_n, sdram_busy;
	sdram_addr_t	spi_address;
	bus_data_t		spi_d;
	bus_data_t		sdram_q, uart_q, expslt0_q, expslt3_q, ppi_q;
	logic			sdram_q_en, uart_q_en, expslt0_q_en, expslt3_q_en, ppi_q_en;
	logic			ppi_cs_n, psg_cs_n, vdp_cs_n;
	sdram_addr_t	sdram_address;
	logic			sdram_mreq_n, sdram_rd_n, sdram_wr_n;
	bus_data_t		sdram_d, cpu_rdata;
	logic			half_enable, cpu_enable, psg_enable;

	integer			seed;
	logic	[31:0]	rnd;
	int				test_mode = MODE_IDLE;		// Selects what the compare process checks
	string			test_name = "reset";
	int				checks = 0;
	int				errors = 0;
	int				test_errors = 0;			// Error count when the current test began
	int				map_area;
	bus_data_t		exp_rdata = 8'hFF;			// Latch model, value after the next edge

	tb_clock_gen u_clock_gen (.clk42m(clk42m), .ff_reset_n(ff_reset_n));
	msx_bus_glue i_msx_bus_glue (.*);

	// ----------------------------------------
	// Reference functions
	// ----------------------------------------
	function automatic logic io_select_ref(bus_addr_t addr, logic iorq, bus_data_t base, int span);
		int port;
		port = int'(addr[7:0]);
		if (port >= int'(base) && port < int'(base) + span)
			return iorq;
		return 1'b1;
	endfunction

	// Lowest priority first, later hits override
	function automatic int area_ref(slot_sel_t pri, slot_sel_t s0, slot_sel_t s3);
		int area;
		area = 10;
		if (s3[2]) area = 9;
		if (s0[0]) area = 8;
		if (s3[1]) area = 7;
		if (s0[1]) area = 6;
		if (s0[2]) area = 5;
		if (s0[3]) area = 4;
		if (pri[2]) area = 3;
		if (pri[1]) area = 2;
		if (s3[0]) area = 1;
		return area;
	endfunction

	function automatic sdram_addr_t sdram_addr_ref(int area, bus_addr_t addr);
		sdram_page_t page;
		case (area)
			1: page = `MSX_PAGE_MAPPER + {7'd0, addr[15:13]};
			2: page = `MSX_PAGE_MEGA1M + {8'd0, ~addr[14], addr[13]};
			3: page = `MSX_PAGE_MEGA512K;
			4: page = `MSX_PAGE_LOGO + {8'd0, addr[14:13]};
			5: page = `MSX_PAGE_MUSIC + {9'd0, addr[13]};
			6: page = `MSX_PAGE_IOT + {9'd0, addr[13]};
			7: page = `MSX_PAGE_SUB + {8'd0, addr[14:13]};
			8: page = `MSX_PAGE_MAIN + {8'd0, addr[14:13]};
			9: page = `MSX_PAGE_NEXTOR + {7'd0, addr[15:13]};
			default: page = '0;
		endcase
		return {page, addr[12:0]};
	endfunction

	function automatic logic read_strobe_ref(int area, bus_addr_t addr, logic iorq, logic rd);
		int cpu_page;
		logic window;
		cpu_page = int'(addr[15:14]);
		case (area)
			1: window = 1'b1;
			2, 3, 4, 9: window = (cpu_page == 1) || (cpu_page == 2);
			5, 6: window = (cpu_page == 1);
			7, 8: window = (cpu_page < 2);				// Lower 32 KB
			default: window = 1'b0;
		endcase
		return (iorq && window) ? rd : 1'b1;
	endfunction

	function automatic bus_data_t latch_ref(bus_data_t held, logic rd, logic [4:0] en,
			bus_data_t q_sdram, bus_data_t q_uart, bus_data_t q_exp0,
			bus_data_t q_exp3, bus_data_t q_ppi);
		bus_data_t src [5];
		bus_data_t next;
		int i;
		src[0] = q_sdram;
		src[1] = q_uart;
		src[2] = q_exp0;
		src[3] = q_exp3;
		src[4] = q_ppi;
		next = rd ? 8'hFF : held;						// Idle bus or held read
		for (i = 4; i >= 0; i--) begin
			if (en[i])
				next = src[i];							// Higher priority overwrites
		end
		return next;
	endfunction

	function automatic slot_sel_t one_hot(logic [2:0] pick);
		case (pick)
			3'd0, 3'd4: return 4'b0001;
			3'd1, 3'd5: return 4'b0010;
			3'd2, 3'd6: return 4'b0100;
			3'd3: return 4'b1000;
			default: return 4'b0000;					// No slot of this group
		endcase
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_select(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_sdram_addr(input string what, input sdram_addr_t expected,
			input sdram_addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_data(input string what, input bus_data_t expected, input bus_data_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic next_random(output logic [31:0] value);
		value = $random(seed);
	endtask

	// ----------------------------------------
	// Waits, each bounded
	// ----------------------------------------
	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		@(negedge clk42m);
		while (!ff_reset_n && n < limit) begin
			@(negedge clk42m);
			n++;
		end
		if (!ff_reset_n) begin
			errors++;
			$display("Timeout: reset was still asserted after %0d cycles", limit);
		end
	endtask

	task automatic wait_cpu_enable(input int limit, output int cycles);
		logic found;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < limit) begin
			@(negedge clk42m);
			cycles++;
			found = cpu_enable;
		end
		if (!found) begin
			errors++;
			$display("Timeout: no cpu_enable pulse within %0d cycles", limit);
		end
	endtask

	// Combinational outputs and the latch, checked mid-cycle
	always @(negedge clk42m) begin
		map_area = area_ref(pri_slot, sub_slot0, sub_slot3);
		case (test_mode)
			MODE_IO: begin
				check_select("ppi_cs_n", io_select_ref(a, iorq_n, `MSX_PPI_PORT, 4), ppi_cs_n);
				check_select("psg_cs_n", io_select_ref(a, iorq_n, `MSX_PSG_PORT, 4), psg_cs_n);
				check_select("vdp_cs_n", io_select_ref(a, iorq_n, `MSX_VDP_PORT, 2), vdp_cs_n);
			end
			MODE_MAP: begin
				check_sdram_addr("sdram_address", sdram_addr_ref(map_area, a), sdram_address);
				check_select("sdram_wr_n", (map_area == 1) ? wr_n : 1'b1, sdram_wr_n);
				check_select("sdram_mreq_n", mreq_n, sdram_mreq_n);
				check_data("sdram_d", d, sdram_d);
			end
			MODE_LOADER: begin
				check_sdram_addr("sdram_address", spi_address, sdram_address);
				check_select("sdram_wr_n", spi_mreq_n, sdram_wr_n);
				check_select("sdram_mreq_n", spi_mreq_n, sdram_mreq_n);
				check_data("sdram_d", spi_d, sdram_d);
			end
			MODE_LATCH: check_data("cpu_rdata", exp_rdata, cpu_rdata);
			default: begin
			end
		endcase
		if (test_mode == MODE_MAP || test_mode == MODE_LOADER)
			check_select("sdram_rd_n", read_strobe_ref(map_area, a, iorq_n, rd_n), sdram_rd_n);
		// Inputs are stable until the next rising edge
		exp_rdata = ff_reset_n ? latch_ref(exp_rdata, rd_n,
			{ppi_q_en, expslt3_q_en, expslt0_q_en, uart_q_en, sdram_q_en},
			sdram_q, uart_q, expslt0_q, expslt3_q, ppi_q) : 8'hFF;
	end

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic run_clock_test();
		int n_cpu, n_psg, n_half, first_cpu, first_psg, k, gap;
		test_name = "clock_enables";
		n_cpu = 0;
		n_psg = 0;
		n_half = 0;
		first_cpu = 0;
		first_psg = 0;
		for (k = 1; k <= 120; k++) begin						// Cycle 1 is the first one out of reset
			if (k > 1)
				@(negedge clk42m);
			if (cpu_enable && first_cpu == 0)
				first_cpu = k;
			if (psg_enable && first_psg == 0)
				first_psg = k;
			n_cpu += cpu_enable ? 1 : 0;
			n_psg += psg_enable ? 1 : 0;
			n_half += half_enable ? 1 : 0;
		end
		check_count("cpu_enable pulses", 20, n_cpu);
		check_count("psg_enable pulses", 10, n_psg);
		check_count("half_enable pulses", 60, n_half);
		check_count("first cpu_enable cycle", 6, first_cpu);
		check_count("first psg_enable cycle", 12, first_psg);
		@(posedge clk42m);
		sdram_busy <= 1'b1;									// Cycles 121 to 141
		for (k = 0; k < 21; k++) begin
			@(negedge clk42m);
			check_select("cpu_enable while busy", 1'b0, cpu_enable);
			check_select("psg_enable while busy", 1'b0, psg_enable);
		end
		@(posedge clk42m);
		sdram_busy <= 1'b0;
		wait_cpu_enable(20, gap);
		check_count("cycles to cpu_enable after busy", 3, gap);	// Count kept running
		repeat (6) @(posedge clk42m);						// CPU count is at its end again
		cpu_freeze <= 1'b1;
		@(negedge clk42m);
		check_select("cpu_enable while frozen", 1'b0, cpu_enable);
		repeat (3) @(posedge clk42m);
		cpu_freeze <= 1'b0;
		wait_cpu_enable(20, gap);
		check_count("cycles to cpu_enable after freeze", 6, gap);
		end_test();
	endtask

	task automatic run_io_test();
		int i;
		test_name = "io_decode";
		test_mode = MODE_IO;
		for (i = 0; i < 200; i++) begin
			@(posedge clk42m);
			next_random(rnd);
			// Odd steps land in 96h-B5h around the ports
			a <= (i % 2 == 1) ? {rnd[15:8], 8'h96 + {3'd0, rnd[4:0]}} : rnd[15:0];
			iorq_n <= rnd[16];
		end
		@(posedge clk42m);
		test_mode = MODE_IDLE;
		end_test();
	endtask

	task automatic run_map_test(input int mode, input string name, input int steps);
		int i;
		test_name = name;
		for (i = 0; i < steps; i++) begin
			@(posedge clk42m);
			next_random(rnd);
			a <= rnd[15:0];
			d <= rnd[23:16];
			mreq_n <= rnd[24];
			iorq_n <= rnd[25];									// Low blocks the read strobe
			rd_n <= rnd[26];
			wr_n <= rnd[27];
			next_random(rnd);
			pri_slot <= one_hot(rnd[2:0]);
			sub_slot0 <= one_hot(rnd[5:3]);
			sub_slot3 <= one_hot(rnd[8:6]);
			cpu_freeze <= (mode == MODE_LOADER);
			next_random(rnd);
			spi_address <= rnd[22:0];
			spi_d <= rnd[30:23];
			spi_mreq_n <= rnd[31];
			test_mode = mode;									// Checked from the first driven step on
		end
		@(posedge clk42m);
		test_mode = MODE_IDLE;
		cpu_freeze <= 1'b0;
		end_test();
	endtask

	task automatic run_latch_test();
		int i;
		test_name = "read_latch";
		test_mode = MODE_LATCH;
		for (i = 0; i < 150; i++) begin
			@(posedge clk42m);
			next_random(rnd);
			sdram_q <= rnd[7:0];
			uart_q <= rnd[15:8];
			expslt0_q <= rnd[23:16];
			expslt3_q <= rnd[31:24];
			next_random(rnd);
			ppi_q <= rnd[7:0];
			rd_n <= rnd[8];
			// One step in four has no responder
			{ppi_q_en, expslt3_q_en, expslt0_q_en, uart_q_en, sdram_q_en} <=
				(rnd[10:9] == 2'b00) ? 5'd0 : rnd[15:11];
		end
		@(posedge clk42m);
		{ppi_q_en, expslt3_q_en, expslt0_q_en, uart_q_en, sdram_q_en} <= 5'd0;
		rd_n <= 1'b1;
		@(posedge clk42m);
		@(negedge clk42m);
		check_data("idle bus", 8'hFF, cpu_rdata);
		@(posedge clk42m);
		test_mode = MODE_IDLE;
		end_test();
	endtask

	initial begin
		seed = 55005;
		a = '0;
		d = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		pri_slot = '0;
		sub_slot0 = '0;
		sub_slot3 = '0;
		cpu_freeze = 1'b0;
		spi_address = '0;
		spi_mreq_n = 1'b1;
		spi_d = '0;
		sdram_busy = 1'b0;
		sdram_q = '0;
		uart_q = '0;
		expslt0_q = '0;
		expslt3_q = '0;
		ppi_q = '0;
		{ppi_q_en, expslt3_q_en, expslt0_q_en, uart_q_en, sdram_q_en} = 5'd0;

		wait_reset_release(20);
		run_clock_test();										// Needs the counters fresh from reset
		run_io_test();
		run_map_test(MODE_MAP, "memory_map", 300);
		run_map_test(MODE_LOADER, "loader_handover", 60);
		run_latch_test();

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+design
design/msx_bus_pkg.sv
design/bus_decode.sv
design/clock_enable_gen.sv
design/read_data_latch.sv
design/msx_bus_glue.sv
verification/tb_clock_gen.sv
verification/tb_msx_bus_glue.sv
